/* hdl/rob_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~
// shared types for the reorder buffer
// instruction, dispatch, result and commit structs
// commit width enum
//~~~~~~~~~~~~~~~~~~~~

package rob_pkg;

	typedef logic [63:0] pc_t;	// program counter
	typedef logic [4:0] arn_t;	// architectural register number
	typedef logic [5:0] prn_t;	// physical register, 64 in the PRF

	// payload kept per entry from dispatch until commit
	typedef struct packed {
		pc_t pc;
		arn_t arn_dest;
		prn_t prn_dest;
		logic is_branch;
	} inst_t;

	// one dispatch slot
	typedef struct packed {
		logic valid;
		inst_t inst;
	} dispatch_t;

	// what a functional unit reports back on completion
	typedef struct packed {
		logic mispredict;	// only meaningful for branches
		pc_t target_pc;
	} result_t;

	// one retirement slot toward the RRAT and fetch redirect
	typedef struct packed {
		logic valid;
		inst_t inst;
		logic mispredict;
		pc_t target_pc;
	} commit_t;

	// how many entries leave the head this cycle
	typedef enum logic [1:0] {
		commit_none = 2'd0,
		commit_one = 2'd1,
		commit_two = 2'd2
	} commit_width_e;

endpackage

/* hdl/rob_entry_store.sv */
//~~~~~~~~~~~~~~~~~~~~
// instruction payload array of the reorder buffer
// two write ports and a two-entry head read window
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module rob_entry_store
	import rob_pkg::*;
#(
	parameter int rob_size = 16
)
(
	input logic clock,

	// dispatch writes
	input logic wr0_en,
	input logic wr1_en,
	input logic [$clog2(rob_size)-1:0] wr0_idx,
	input logic [$clog2(rob_size)-1:0] wr1_idx,
	input inst_t wr0_inst,
	input inst_t wr1_inst,

	// head window
	input logic [$clog2(rob_size)-1:0] head_idx,
	output inst_t head_inst,
	output inst_t next_inst
);

	localparam int idx_w = $clog2(rob_size);

	inst_t entries [rob_size];
	logic [idx_w-1:0] next_idx;

	// power-of-two size, so the add wraps on its own
	assign next_idx = head_idx + idx_w'(1);

	// no reset here, occupancy is tracked by the control block
	always_ff @(posedge clock)
	begin
		if (wr0_en)
		begin
			entries[wr0_idx] <= wr0_inst;
		end
		if (wr1_en)
		begin
			entries[wr1_idx] <= wr1_inst;	// never the same slot as port 0
		end
	end

	assign head_inst = entries[head_idx];
	assign next_inst = entries[next_idx];

endmodule

/* hdl/rob_completion_table.sv */
//~~~~~~~~~~~~~~~~~~~~
// per-entry completion state of the reorder buffer
// done and mispredict bits, branch targets, head window read
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module rob_completion_table
	import rob_pkg::*;
#(
	parameter int rob_size = 16
)
(
	input logic clock,
	input logic reset,

	// dispatch clears the entries it allocates
	input logic clear0_en,
	input logic clear1_en,
	input logic [$clog2(rob_size)-1:0] clear0_idx,
	input logic [$clog2(rob_size)-1:0] clear1_idx,

	// completion ports from the functional units
	input logic complete0_valid,
	input logic complete1_valid,
	input logic [$clog2(rob_size)-1:0] complete0_idx,
	input logic [$clog2(rob_size)-1:0] complete1_idx,
	input result_t complete0_result,
	input result_t complete1_result,

	input logic [$clog2(rob_size)-1:0] head_idx,
	output logic head_done,
	output logic next_done,
	output result_t head_result,
	output result_t next_result
);

	localparam int idx_w = $clog2(rob_size);

	logic [rob_size-1:0] done;
	logic [rob_size-1:0] mispredict;
	pc_t target [rob_size];
	logic [idx_w-1:0] next_idx;

	assign next_idx = head_idx + idx_w'(1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			done <= '0;
			mispredict <= '0;
		end
		else
		begin
			// clear and set never hit the same entry in one cycle
			if (clear0_en)
			begin
				done[clear0_idx] <= 1'b0;
				mispredict[clear0_idx] <= 1'b0;
			end
			if (clear1_en)
			begin
				done[clear1_idx] <= 1'b0;
				mispredict[clear1_idx] <= 1'b0;
			end
			if (complete0_valid)
			begin
				done[complete0_idx] <= 1'b1;
				mispredict[complete0_idx] <= complete0_result.mispredict;
			end
			if (complete1_valid)
			begin
				done[complete1_idx] <= 1'b1;
				mispredict[complete1_idx] <= complete1_result.mispredict;
			end
		end
	end

	// targets are payload, only read once done is set
	always_ff @(posedge clock)
	begin
		if (complete0_valid)
			target[complete0_idx] <= complete0_result.target_pc;
		if (complete1_valid)
			target[complete1_idx] <= complete1_result.target_pc;
	end

	assign head_done = done[head_idx];
	assign next_done = done[next_idx];
	assign head_result = '{mispredict: mispredict[head_idx], target_pc: target[head_idx]};
	assign next_result = '{mispredict: mispredict[next_idx], target_pc: target[next_idx]};

endmodule

/* hdl/rob_control.sv */
//~~~~~~~~~~~~~~~~~~~~
// reorder buffer control
// head, tail and count, allocation, commit and flush, full flag
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module rob_control
	import rob_pkg::*;
#(
	parameter int rob_size = 16
)
(
	input logic clock,
	input logic reset,

	input dispatch_t dispatch0,
	input dispatch_t dispatch1,

	// head window from the store and the completion table
	input inst_t head_inst,
	input inst_t next_inst,
	input logic head_done,
	input logic next_done,
	input result_t head_result,
	input result_t next_result,

	output logic [$clog2(rob_size)-1:0] dispatch_idx0,
	output logic [$clog2(rob_size)-1:0] dispatch_idx1,
	output logic [$clog2(rob_size)-1:0] head_idx,
	output logic wr0_en,
	output logic wr1_en,
	output commit_t commit0,
	output commit_t commit1,
	output logic full
);

	localparam int idx_w = $clog2(rob_size);
	localparam int cnt_w = idx_w + 1;	// count reaches rob_size

	logic [idx_w-1:0] head;
	logic [idx_w-1:0] tail;
	logic [cnt_w-1:0] count;
	logic [idx_w-1:0] head_next;
	logic [idx_w-1:0] tail_next;
	logic [cnt_w-1:0] count_next;

	commit_width_e commit_width;
	logic [1:0] n_commit;
	logic [1:0] n_dispatch;
	logic head_misp;
	logic next_misp;
	logic flush;

	// a mispredicted branch at slot 0 blocks slot 1
	assign head_misp = head_inst.is_branch & head_result.mispredict;
	assign next_misp = next_inst.is_branch & next_result.mispredict;

	always_comb
	begin
		commit_width = commit_none;
		if (count != '0 && head_done)
		begin
			commit_width = commit_one;
			if (count > cnt_w'(1) && next_done && !head_misp)
				commit_width = commit_two;
		end
	end

	assign n_commit = commit_width;
	assign flush = (commit_width != commit_none && head_misp)
		|| (commit_width == commit_two && next_misp);

	// a flushing cycle drops any dispatch that arrives with it
	assign wr0_en = dispatch0.valid & ~flush;
	assign wr1_en = dispatch1.valid & ~flush;
	assign n_dispatch = {1'b0, wr0_en} + {1'b0, wr1_en};

	assign head_next = head + idx_w'(n_commit);
	assign tail_next = flush ? head_next : tail + idx_w'(n_dispatch);
	assign count_next = flush ? '0 : count - cnt_w'(n_commit) + cnt_w'(n_dispatch);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			head <= head_next;
			tail <= tail_next;
			count <= count_next;
		end
	end

	assign head_idx = head;
	assign dispatch_idx0 = tail;
	assign dispatch_idx1 = tail + idx_w'(1);

	assign full = count >= cnt_w'(rob_size - 1);	// fewer than two free

	assign commit0 = '{valid: commit_width != commit_none, inst: head_inst,
		mispredict: head_result.mispredict, target_pc: head_result.target_pc};
	assign commit1 = '{valid: commit_width == commit_two, inst: next_inst,
		mispredict: next_result.mispredict, target_pc: next_result.target_pc};

endmodule

/* hdl/rob_top.sv */
//~~~~~~~~~~~~~~~~~~~~
// two-wide reorder buffer top level
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module rob_top
	import rob_pkg::*;
#(
	parameter int rob_size = 16	// power of two
)
(
	input logic clock,
	input logic reset,

	input dispatch_t dispatch0,
	input dispatch_t dispatch1,
	output logic [$clog2(rob_size)-1:0] dispatch_idx0,
	output logic [$clog2(rob_size)-1:0] dispatch_idx1,

	input logic complete0_valid,
	input logic [$clog2(rob_size)-1:0] complete0_idx,
	input result_t complete0_result,
	input logic complete1_valid,
	input logic [$clog2(rob_size)-1:0] complete1_idx,
	input result_t complete1_result,

	output commit_t commit0,
	output commit_t commit1,
	output logic full
);

	localparam int idx_w = $clog2(rob_size);

	logic [idx_w-1:0] head_idx;
	logic wr0_en;
	logic wr1_en;
	inst_t head_inst;
	inst_t next_inst;
	logic head_done;
	logic next_done;
	result_t head_result;
	result_t next_result;

	rob_control #(.rob_size(rob_size)) control (
		.clock(clock),
		.reset(reset),
		.dispatch0(dispatch0),
		.dispatch1(dispatch1),
		.head_inst(head_inst),
		.next_inst(next_inst),
		.head_done(head_done),
		.next_done(next_done),
		.head_result(head_result),
		.next_result(next_result),
		.dispatch_idx0(dispatch_idx0),
		.dispatch_idx1(dispatch_idx1),
		.head_idx(head_idx),
		.wr0_en(wr0_en),
		.wr1_en(wr1_en),
		.commit0(commit0),
		.commit1(commit1),
		.full(full)
	);

	rob_entry_store #(.rob_size(rob_size)) entry_store (
		.clock(clock),
		.wr0_en(wr0_en),
		.wr1_en(wr1_en),
		.wr0_idx(dispatch_idx0),
		.wr1_idx(dispatch_idx1),
		.wr0_inst(dispatch0.inst),
		.wr1_inst(dispatch1.inst),
		.head_idx(head_idx),
		.head_inst(head_inst),
		.next_inst(next_inst)
	);

	// dispatch writes double as clears of the completion state
	rob_completion_table #(.rob_size(rob_size)) completion_table (
		.clock(clock),
		.reset(reset),
		.clear0_en(wr0_en),
		.clear1_en(wr1_en),
		.clear0_idx(dispatch_idx0),
		.clear1_idx(dispatch_idx1),
		.complete0_valid(complete0_valid),
		.complete1_valid(complete1_valid),
		.complete0_idx(complete0_idx),
		.complete1_idx(complete1_idx),
		.complete0_result(complete0_result),
		.complete1_result(complete1_result),
		.head_idx(head_idx),
		.head_done(head_done),
		.next_done(next_done),
		.head_result(head_result),
		.next_result(next_result)
	);

endmodule

/* dv/tb_clock_gen.sv */
//~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_clock_gen
#(
	parameter int reset_cycles = 16
)
(
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;	// 4 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;	// released on a falling edge
	end

endmodule

/* dv/rob_chk.sv */
//~~~~~~~~~~~~~~~~~~~~
// ordering and occupancy assertions for rob_control
// bound into every rob_control instance
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module rob_chk
	import rob_pkg::*;
#(
	parameter int rob_size = 16
)
(
	input logic clock,
	input logic reset,
	input logic wr0_en,
	input logic wr1_en,
	input logic full,
	input logic [$clog2(rob_size):0] count,
	input commit_t commit0,
	input commit_t commit1
);

	int failures = 0;	// polled by the testbench top
	logic flush_seen;

	// a committed mispredicted branch in either slot
	assign flush_seen = (commit0.valid & commit0.inst.is_branch & commit0.mispredict)
		| (commit1.valid & commit1.inst.is_branch & commit1.mispredict);

	// slot 1 only behind a committing slot 0 that does not redirect
	commit_in_order: assert property (@(posedge clock) disable iff (reset)
		commit1.valid |-> commit0.valid && !(commit0.inst.is_branch && commit0.mispredict))
	else
	begin
		failures++;
		$error("commit slot 1 valid without slot 0");
	end

	no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
		full |-> !(wr0_en || wr1_en))
	else
	begin
		failures++;
		$error("dispatch accepted while full");
	end

	count_in_range: assert property (@(posedge clock) disable iff (reset)
		count <= ($clog2(rob_size) + 1)'(rob_size))
	else
	begin
		failures++;
		$error("occupancy count above buffer size");
	end

	flush_empties: assert property (@(posedge clock) disable iff (reset)
		flush_seen |=> count == '0)
	else
	begin
		failures++;
		$error("count not zero after a mispredict flush");
	end

endmodule

bind rob_control rob_chk #(.rob_size(rob_size)) chk (
	.clock(clock),
	.reset(reset),
	.wr0_en(wr0_en),
	.wr1_en(wr1_en),
	.full(full),
	.count(count),
	.commit0(commit0),
	.commit1(commit1)
);

/* dv/rob_tb.sv */
//~~~~~~~~~~~~~~~~~~~~
// reorder buffer testbench top
// LCG stimulus, reference queue model, commit and index checks
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module rob_tb
	import rob_pkg::*;
();

	localparam int rob_size = 16;
	localparam int idx_w = $clog2(rob_size);
	localparam logic [31:0] seed = 32'h3be4_0457;
	localparam int reset_cycles = 16;
	localparam int random_cycles = 800;
	localparam int fill_cycles = 18;
	localparam int flush_cycles = 8;
	localparam int drain_cycles = 20;	// allowance for each of the four drains
	localparam int timeout_cycles = reset_cycles + random_cycles + fill_cycles
		+ flush_cycles + 4 * drain_cycles + 200;

	// one in-flight instruction as the model sees it
	typedef struct packed {
		logic [idx_w-1:0] idx;
		logic done;
		inst_t inst;
		result_t result;
	} model_entry_t;

	logic clock;
	logic reset;
	dispatch_t dispatch0;
	dispatch_t dispatch1;
	logic [idx_w-1:0] dispatch_idx0;
	logic [idx_w-1:0] dispatch_idx1;
	logic complete0_valid;
	logic complete1_valid;
	logic [idx_w-1:0] complete0_idx;
	logic [idx_w-1:0] complete1_idx;
	result_t complete0_result;
	result_t complete1_result;
	commit_t commit0;
	commit_t commit1;
	logic full;

	model_entry_t model_q[$];	// oldest first
	logic [idx_w-1:0] model_tail;
	logic [31:0] lcg_state;
	pc_t next_pc;
	int cycles;

	tb_clock_gen #(.reset_cycles(reset_cycles)) clock_gen (.clock(clock), .reset(reset));

	rob_top #(.rob_size(rob_size)) dut (.*);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;	// low bits of an LCG repeat quickly
	endfunction

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_commit(input string name, input commit_t expected,
		input commit_t actual);
		if (expected.valid !== actual.valid || (expected.valid && expected !== actual))
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_idx(input string name, input logic [idx_w-1:0] expected,
		input logic [idx_w-1:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (expected !== actual)
		begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			stop_run();
		end
	endtask

	// commit rule applied to the model queue
	function automatic commit_t expected_commit(input int slot);
		commit_t c;
		logic head_ok;
		c = '0;
		head_ok = model_q.size() > 0 && model_q[0].done;
		if (slot == 0)
			c.valid = head_ok;
		else
			c.valid = head_ok && model_q.size() > 1 && model_q[1].done
				&& !(model_q[0].inst.is_branch && model_q[0].result.mispredict);
		if (c.valid)
		begin
			c.inst = model_q[slot].inst;
			c.mispredict = model_q[slot].result.mispredict;
			c.target_pc = model_q[slot].result.target_pc;
		end
		return c;
	endfunction

	task automatic mark_done(input logic [idx_w-1:0] idx, input result_t result);
		model_entry_t e;
		foreach (model_q[i])
		begin
			if (model_q[i].idx == idx)
			begin
				e = model_q[i];
				e.done = 1'b1;
				e.result = result;
				model_q[i] = e;
			end
		end
	endtask

	task automatic push_dispatch(input inst_t inst);
		model_q.push_back('{idx: model_tail, done: 1'b0, inst: inst, result: '0});
		model_tail = model_tail + 1'b1;
	endtask

	// advance the model by one clock edge
	task automatic update_model();
		commit_t c0;
		commit_t c1;
		logic flush;
		logic [idx_w-1:0] tail_after_flush;
		c0 = expected_commit(0);
		c1 = expected_commit(1);
		flush = (c0.valid && c0.inst.is_branch && c0.mispredict)
			|| (c1.valid && c1.inst.is_branch && c1.mispredict);
		tail_after_flush = model_tail;
		if (complete0_valid)
			mark_done(complete0_idx, complete0_result);
		if (complete1_valid)
			mark_done(complete1_idx, complete1_result);
		if (c0.valid)
		begin
			tail_after_flush = model_q[0].idx + 1'b1;
			model_q.delete(0);
		end
		if (c1.valid)
		begin
			tail_after_flush = model_q[0].idx + 1'b1;
			model_q.delete(0);
		end
		if (flush)
		begin
			model_q.delete();	// same-cycle dispatch is lost too
			model_tail = tail_after_flush;
		end
		else
		begin
			if (dispatch0.valid)
				push_dispatch(dispatch0.inst);
			if (dispatch1.valid)
				push_dispatch(dispatch1.inst);
		end
	endtask

	always @(posedge clock)
	begin
		if (reset == 1'b0)
		begin
			check_commit("commit slot 0", expected_commit(0), commit0);
			check_commit("commit slot 1", expected_commit(1), commit1);
			check_idx("dispatch index 0", model_tail, dispatch_idx0);
			check_idx("dispatch index 1", model_tail + 1'b1, dispatch_idx1);
			check_flag("full flag", (rob_size - model_q.size()) < 2, full);
			update_model();
		end
	end

	initial
		cycles = 0;

	always @(negedge clock)
	begin
		cycles = cycles + 1;
		if (dut.control.chk.failures != 0)
		begin
			$display("an assertion in rob_chk failed at cycle %0d", cycles);
			stop_run();
		end
		else if (cycles > timeout_cycles)
		begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			stop_run();
		end
	end

	task automatic clear_inputs();
		dispatch0 = '0;
		dispatch1 = '0;
		complete0_valid = 1'b0;
		complete1_valid = 1'b0;
		complete0_idx = '0;
		complete1_idx = '0;
		complete0_result = '0;
		complete1_result = '0;
	endtask

	function automatic inst_t make_inst(input logic branch);
		inst_t inst;
		logic [31:0] r;
		r = next_random();
		inst.pc = next_pc;	// unique, so a stale entry cannot match
		inst.arn_dest = r[4:0];
		inst.prn_dest = r[10:5];
		inst.is_branch = branch;
		next_pc = next_pc + 64'd4;
		return inst;
	endfunction

	task automatic drive_dispatch(input int n, input logic [1:0] branch);
		if (n > 0)
			dispatch0 = '{valid: 1'b1, inst: make_inst(branch[0])};
		if (n > 1)
			dispatch1 = '{valid: 1'b1, inst: make_inst(branch[1])};
	endtask

	// complete the model entry at queue position pos
	task automatic drive_completion(input int port, input int pos, input logic misp);
		result_t res;
		res.mispredict = misp & model_q[pos].inst.is_branch;
		res.target_pc = {next_random(), next_random()};
		if (port == 0)
		begin
			complete0_valid = 1'b1;
			complete0_idx = model_q[pos].idx;
			complete0_result = res;
		end
		else
		begin
			complete1_valid = 1'b1;
			complete1_idx = model_q[pos].idx;
			complete1_result = res;
		end
	endtask

	function automatic int pick_pending(input int avoid);
		int pending[$];
		foreach (model_q[i])
			if (!model_q[i].done && i != avoid)
				pending.push_back(i);
		if (pending.size() == 0)
			return -1;
		return pending[next_random() % pending.size()];
	endfunction

	task automatic random_cycle();
		logic [31:0] r;
		int n;
		int p0;
		int p1;
		r = next_random();
		n = (model_q.size() < rob_size - 1) ? int'(r[1:0]) % 3 : 0;	// only while not full
		drive_dispatch(n, {r[5:4] == 2'd0, r[3:2] == 2'd0});
		p0 = r[6] ? pick_pending(-1) : -1;
		if (p0 >= 0)
			drive_completion(0, p0, r[10:8] == 3'd0);
		p1 = r[7] ? pick_pending(p0) : -1;
		if (p1 >= 0)
			drive_completion(1, p1, r[13:11] == 3'd0);
	endtask

	// complete everything still pending, no new dispatch
	task automatic drain();
		int p0;
		int p1;
		do
		begin
			@(negedge clock);
			clear_inputs();
			p0 = pick_pending(-1);
			if (p0 >= 0)
				drive_completion(0, p0, 1'b0);
			p1 = pick_pending(p0);
			if (p1 >= 0)
				drive_completion(1, p1, 1'b0);
		end
		while (model_q.size() != 0);
	endtask

	initial
	begin
		lcg_state = seed;
		next_pc = 64'h0000_0000_8000_0000;
		model_tail = '0;
		clear_inputs();
		wait (reset == 1'b0);

		// random dispatch, completion and mispredicts
		repeat (random_cycles)
		begin
			@(negedge clock);
			clear_inputs();
			random_cycle();
		end
		drain();

		// fill one per cycle until full, then hold
		repeat (fill_cycles)
		begin
			@(negedge clock);
			clear_inputs();
			if (model_q.size() < rob_size - 1)
				drive_dispatch(1, 2'b00);
		end
		drain();

		// mispredict in slot 1, with a dispatch in the flush cycle
		@(negedge clock);
		clear_inputs();
		drive_dispatch(2, 2'b10);
		@(negedge clock);
		clear_inputs();
		drive_dispatch(2, 2'b00);
		@(negedge clock);
		clear_inputs();
		drive_completion(0, 2, 1'b0);
		drive_completion(1, 3, 1'b0);
		@(negedge clock);
		clear_inputs();
		drive_completion(0, 1, 1'b1);
		drive_completion(1, 0, 1'b0);
		@(negedge clock);
		clear_inputs();
		drive_dispatch(2, 2'b00);	// lands in the flush cycle
		drain();

		// mispredict at the head blocks slot 1
		@(negedge clock);
		clear_inputs();
		drive_dispatch(2, 2'b01);
		@(negedge clock);
		clear_inputs();
		drive_completion(0, 0, 1'b1);
		drive_completion(1, 1, 1'b0);
		drain();

		repeat (4) @(negedge clock);
		if (dut.control.chk.failures == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
		begin
			$display("an assertion in rob_chk failed");
			stop_run();
		end
	end

endmodule

/* list.f */
hdl/rob_pkg.sv
hdl/rob_entry_store.sv
hdl/rob_completion_table.sv
hdl/rob_control.sv
hdl/rob_top.sv
dv/tb_clock_gen.sv
dv/rob_chk.sv
dv/rob_tb.sv

/* Makefile */
# Verilator build and run of the reorder buffer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rob_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUN_FLAGS ?= +verilator+error+limit+100
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
